// ==== files.f ====
+incdir+source
source/bmu_op_pkg.sv
source/bmu_data_pkg.sv
source/zero_counter.sv
source/pop_counter.sv
source/bmu_issue_stage.sv
source/bmu_writeback_stage.sv
source/bit_count_unit.sv
tests/bit_count_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bit_count_unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f files.f \
    --top-module bit_count_unit_tb -o sim_bit_count_unit \
    && ./obj_dir/sim_bit_count_unit > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "Verification passed" sim.log 2>/dev/null && exit 0 || exit 1

// ==== tests/bit_count_unit_tb.sv ====
// directed checks against a bit-scanning model; assumes a fixed two-edge latency and no stall.
`timescale 1ns/100ps
`default_nettype none

`include "bmu_defines.svh"

module bit_count_unit_tb;
    import bmu_op_pkg::*;
    import bmu_data_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    bmu_req_t    req;
    logic        res_valid;
    bmu_result_t res;

    bmu_result_t exp_q [$];  // expected results, oldest first.
    int          errors  = 0;
    int          passed  = 0;
    int          failed  = 0;
    int          strobes = 0;

    bit_count_unit uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .res_valid (res_valid),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int lead_zeros(input logic [`BMU_XLEN-1:0] v);
        int  n;
        bit  found;
        n = 0;
        found = 1'b0;
        for (int i = `BMU_XLEN - 1; i >= 0; i--) begin
            if (v[i]) found = 1'b1;
            if (!found) n++;
        end
        return n;
    endfunction

    function automatic int trail_zeros(input logic [`BMU_XLEN-1:0] v);
        int  n;
        bit  found;
        n = 0;
        found = 1'b0;
        for (int i = 0; i < `BMU_XLEN; i++) begin
            if (v[i]) found = 1'b1;
            if (!found) n++;
        end
        return n;
    endfunction

    function automatic int ones_count(input logic [`BMU_XLEN-1:0] v);
        int n;
        n = 0;
        for (int i = 0; i < `BMU_XLEN; i++) begin
            if (v[i]) n++;
        end
        return n;
    endfunction

    function automatic bmu_result_t model_result(input bmu_req_t r);
        bmu_result_t m;
        m.tag = r.tag;
        m.illegal = 1'b0;
        m.value = '0;
        case (r.op)
            OP_CLZ:  m.value = lead_zeros(r.operand);
            OP_CTZ:  m.value = trail_zeros(r.operand);
            OP_CPOP: m.value = ones_count(r.operand);
            default: m.illegal = 1'b1;  // value stays zero.
        endcase
        return m;
    endfunction

    function automatic bmu_req_t make_req(input bmu_op_t op, input logic [31:0] v,
                                          input logic [4:0] tag);
        bmu_req_t r;
        r.op = op;
        r.operand = v;
        r.tag = tag;
        return r;
    endfunction

    task automatic check_result(input bmu_result_t exp, input bmu_result_t act);
        if (act.value !== exp.value) begin
            $display("ERROR %0t res.value expected %h got %h", $time, exp.value, act.value);
            errors++;
        end
        if (act.tag !== exp.tag) begin
            $display("ERROR %0t res.tag expected %0d got %0d", $time, exp.tag, act.tag);
            errors++;
        end
        if (act.illegal !== exp.illegal) begin
            $display("ERROR %0t res.illegal expected %b got %b", $time, exp.illegal, act.illegal);
            errors++;
        end
    endtask

    task automatic check_valid(input logic exp, input logic act, input string name);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            passed++;
            $display("%s: ok", name);
        end else begin
            failed++;
            $display("%s: %0d errors", name, errors - err0);
        end
    endtask

    // one request alone, then wait for its strobe.
    task automatic run_single(input bmu_op_t op, input logic [31:0] v, input logic [4:0] tag);
        bmu_req_t    r;
        bmu_result_t exp;
        int          waited;
        r = make_req(op, v, tag);
        exp = model_result(r);
        @(negedge clk);
        req_valid = 1'b1;
        req = r;
        @(negedge clk);
        req_valid = 1'b0;
        req = '0;
        waited = 1;
        while (!res_valid && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (!res_valid) begin
            $display("%0t: no result strobe within 10 cycles for tag %0d", $time, tag);
            errors++;
        end else begin
            if (waited != 2) begin
                $display("%0t: result for tag %0d came %0d edges after its strobe, not 2",
                         $time, tag, waited);
                errors++;
            end
            check_result(exp, res);
            @(negedge clk);
            check_valid(1'b0, res_valid, "res_valid");  // strobe lasts one cycle.
        end
    endtask

    task automatic collect_result();
        bmu_result_t exp;
        if (res_valid) begin
            strobes++;
            if (exp_q.size() == 0) begin
                $display("%0t: result strobe with no request outstanding", $time);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                check_result(exp, res);
            end
        end
    endtask

    // sample first, then drive, all on the falling edge.
    task automatic issue_req(input bmu_req_t r);
        @(negedge clk);
        collect_result();
        req_valid = 1'b1;
        req = r;
        exp_q.push_back(model_result(r));
    endtask

    task automatic drain_results();
        int waited;
        @(negedge clk);
        collect_result();
        req_valid = 1'b0;
        req = '0;
        waited = 0;
        while (exp_q.size() > 0 && waited < 10) begin
            @(negedge clk);
            collect_result();
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("%0t: %0d results still missing after 10 cycles", $time, exp_q.size());
            errors++;
            exp_q.delete();
        end
        @(negedge clk);
        check_valid(1'b0, res_valid, "res_valid");
    endtask

    task automatic reset_idle();
        int err0;
        err0 = errors;
        repeat (5) begin
            @(negedge clk);
            check_valid(1'b0, res_valid, "res_valid");
        end
        check_result(bmu_result_t'('0), res);
        report_test("reset idle", err0);
    endtask

    task automatic edge_operands();
        logic [31:0] vals [5];
        int          err0;
        err0 = errors;
        vals = '{32'h0000_0000, 32'h0000_0001, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0040};
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < 5; j++) begin
                run_single(bmu_op_t'(k), vals[j], 5'(5 * k + j));
            end
        end
        report_test("edge operands", err0);
    endtask

    task automatic walking_one();
        int err0;
        err0 = errors;
        for (int i = 0; i < 32; i++) begin
            run_single(OP_CTZ, 32'd1 << i, 5'(i));
            run_single(OP_CLZ, 32'd1 << i, 5'(31 - i));
        end
        report_test("walking one", err0);
    endtask

    task automatic random_stream();
        bmu_req_t r;
        int       err0;
        int       a;
        int       b;
        err0 = errors;
        strobes = 0;
        for (int n = 0; n < 200; n++) begin
            a = $urandom_range(31, 0);
            b = $urandom_range(31, 0);
            r = make_req(bmu_op_t'($urandom_range(3, 0)), ($urandom() >> a) << b, 5'(n));
            issue_req(r);
        end
        drain_results();
        if (strobes != 200) begin
            $display("%0t: saw %0d result strobes for 200 requests", $time, strobes);
            errors++;
        end
        report_test("random stream", err0);
    endtask

    task automatic illegal_op();
        int err0;
        err0 = errors;
        run_single(OP_RSVD, 32'hdead_beef, 5'd17);
        strobes = 0;
        issue_req(make_req(OP_CTZ, 32'h0000_0100, 5'd1));
        issue_req(make_req(OP_RSVD, 32'h1234_5678, 5'd2));
        issue_req(make_req(OP_CPOP, 32'h0f0f_0f0f, 5'd3));
        issue_req(make_req(OP_RSVD, 32'h0000_0000, 5'd4));
        issue_req(make_req(OP_CLZ, 32'h0001_0000, 5'd5));
        drain_results();
        if (strobes != 5) begin
            $display("%0t: saw %0d result strobes for 5 requests", $time, strobes);
            errors++;
        end
        report_test("illegal op", err0);
    endtask

    initial begin
        void'($urandom(10043));
        rst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_idle();
        edge_operands();
        walking_one();
        random_stream();
        illegal_op();
        $display("tests: %0d passed, %0d failed, %0d check errors", passed, failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/bit_count_unit.sv ====
// clz, ctz and cpop with a fixed two-edge latency; results return in request order.
`timescale 1ns/100ps
`default_nettype none

`include "bmu_defines.svh"

module bit_count_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  bmu_data_pkg::bmu_req_t    req,
    output logic                      res_valid,
    output bmu_data_pkg::bmu_result_t res
);
    import bmu_data_pkg::*;

    logic                  iss_valid;
    bmu_issued_t           iss;
    logic [`BMU_CNT_W-1:0] sifir_sayisi;
    logic                  hepsi_sifir;
    logic [`BMU_CNT_W:0]   pop_count;

    bmu_issue_stage u_issue (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .iss_valid (iss_valid),
        .iss       (iss)
    );

    zero_counter u_zero (
        .deger_i      (iss.count_operand),
        .sifir_sayisi (sifir_sayisi),
        .hepsi_sifir  (hepsi_sifir)
    );

    pop_counter u_pop (
        .operand   (iss.operand),
        .pop_count (pop_count)
    );

    bmu_writeback_stage u_wb (
        .clk        (clk),
        .rst_n      (rst_n),
        .iss_valid  (iss_valid),
        .sel        (iss.sel),
        .tag        (iss.tag),
        .zero_count (sifir_sayisi),
        .all_zero   (hepsi_sifir),
        .pop_count  (pop_count),
        .res_valid  (res_valid),
        .res        (res)
    );

endmodule

`default_nettype wire

// ==== source/bmu_writeback_stage.sv ====
// result must be taken on the cycle res_valid is high; nothing is held for a slow consumer.
`timescale 1ns/100ps
`default_nettype none

`include "bmu_defines.svh"

module bmu_writeback_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      iss_valid,
    input  bmu_op_pkg::bmu_sel_t      sel,
    input  logic [`BMU_TAG_W-1:0]     tag,
    input  logic [`BMU_CNT_W-1:0]     zero_count,
    input  logic                      all_zero,
    input  logic [`BMU_CNT_W:0]       pop_count,
    output logic                      res_valid,
    output bmu_data_pkg::bmu_result_t res
);
    import bmu_data_pkg::*;

    localparam logic [`BMU_XLEN-1:0] FULL_COUNT = `BMU_XLEN;

    bmu_result_t res_d;

    always_comb begin
        res_d.tag     = tag;
        res_d.illegal = sel.illegal;
        res_d.value   = '0;
        if (sel.illegal) begin
            res_d.value = '0;
        end else if (sel.is_count) begin
            if (all_zero) begin
                res_d.value = FULL_COUNT;  // no set bit, full width.
            end else begin
                res_d.value = {{(`BMU_XLEN-`BMU_CNT_W){1'b0}}, zero_count};
            end
        end else if (sel.is_pop) begin
            res_d.value = {{(`BMU_XLEN-`BMU_CNT_W-1){1'b0}}, pop_count};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            res       <= '0;
        end else begin
            res_valid <= iss_valid;
            if (iss_valid) begin
                res <= res_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/bmu_issue_stage.sv ====
// one request per cycle, no back-pressure; payload only loads on a strobe and holds otherwise.
`timescale 1ns/100ps
`default_nettype none

`include "bmu_defines.svh"

module bmu_issue_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  bmu_data_pkg::bmu_req_t  req,
    output logic                    iss_valid,
    output bmu_data_pkg::bmu_issued_t iss
);
    import bmu_op_pkg::*;
    import bmu_data_pkg::*;

    bmu_sel_t             sel_d;
    logic [`BMU_XLEN-1:0] rev_operand;
    bmu_issued_t          iss_d;

    always_comb begin
        sel_d = '0;
        case (req.op)
            OP_CLZ:  sel_d.is_count = 1'b1;
            OP_CTZ:  sel_d.is_count = 1'b1;
            OP_CPOP: sel_d.is_pop   = 1'b1;
            default: sel_d.illegal  = 1'b1;
        endcase
    end

    // leading zeros become trailing zeros.
    always_comb begin
        for (int i = 0; i < `BMU_XLEN; i++) begin
            rev_operand[i] = req.operand[`BMU_XLEN-1-i];
        end
    end

    always_comb begin
        iss_d.sel           = sel_d;
        iss_d.count_operand = (req.op == OP_CLZ) ? rev_operand : req.operand;
        iss_d.operand       = req.operand;
        iss_d.tag           = req.tag;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            iss_valid <= 1'b0;
            iss       <= '0;
        end else begin
            iss_valid <= req_valid;
            if (req_valid) begin
                iss <= iss_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/pop_counter.sv ====
// combinational cpop of a 32-bit word as a five-level adder tree; output is 0 to 32.
`timescale 1ns/100ps
`default_nettype none

`include "bmu_defines.svh"

module pop_counter (
    input  logic [`BMU_XLEN-1:0] operand,
    output logic [`BMU_CNT_W:0]  pop_count
);
    logic [1:0] lvl1 [16];  // pairs of bits.
    logic [2:0] lvl2 [8];
    logic [3:0] lvl3 [4];
    logic [4:0] lvl4 [2];

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            lvl1[i] = {1'b0, operand[2*i]} + {1'b0, operand[2*i+1]};
        end
        for (int i = 0; i < 8; i++) begin
            lvl2[i] = {1'b0, lvl1[2*i]} + {1'b0, lvl1[2*i+1]};
        end
        for (int i = 0; i < 4; i++) begin
            lvl3[i] = {1'b0, lvl2[2*i]} + {1'b0, lvl2[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            lvl4[i] = {1'b0, lvl3[2*i]} + {1'b0, lvl3[2*i+1]};
        end
    end

    // last level needs the extra bit for 32.
    assign pop_count = {1'b0, lvl4[0]} + {1'b0, lvl4[1]};

endmodule

`default_nettype wire

// ==== source/zero_counter.sv ====
// combinational ctz of a 32-bit word; the count reads 0 when hepsi_sifir is high.
`timescale 1ns/100ps
`default_nettype none

`include "bmu_defines.svh"

module zero_counter (
    input  logic [`BMU_XLEN-1:0]  deger_i,
    output logic [`BMU_CNT_W-1:0] sifir_sayisi,
    output logic                  hepsi_sifir
);
    localparam int NBYTES = `BMU_XLEN / 8;

    logic [NBYTES-1:0] byte_nz;
    logic [1:0]        byte_idx;
    logic [7:0]        low_byte;
    logic [2:0]        bit_idx;

    assign hepsi_sifir = ~(|deger_i);

    always_comb begin
        for (int i = 0; i < NBYTES; i++) begin
            byte_nz[i] = |deger_i[i*8 +: 8];
        end
    end

    // lowest non-zero byte, scanned top down so the lowest wins.
    always_comb begin
        byte_idx = 2'd0;
        for (int i = NBYTES - 1; i >= 0; i--) begin
            if (byte_nz[i]) begin
                byte_idx = i[1:0];
            end
        end
    end

    assign low_byte = deger_i[byte_idx*8 +: 8];

    // lowest set bit inside that byte.
    always_comb begin
        bit_idx = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (low_byte[i]) begin
                bit_idx = i[2:0];
            end
        end
    end

    // byte index above bit index.
    assign sifir_sayisi = {byte_idx, bit_idx};

endmodule

`default_nettype wire

// ==== source/bmu_data_pkg.sv ====
// payload structs sized by bmu_defines.svh; tags are carried through unchanged, not checked.
`default_nettype none

package bmu_data_pkg;

    `include "bmu_defines.svh"

    typedef struct packed {
        bmu_op_pkg::bmu_op_t          op;
        logic [`BMU_XLEN-1:0]         operand;
        logic [`BMU_TAG_W-1:0]        tag;
    } bmu_req_t;

    // operand after decode, as seen by the counters.
    typedef struct packed {
        bmu_op_pkg::bmu_sel_t         sel;
        logic [`BMU_XLEN-1:0]         count_operand;  // reversed for clz.
        logic [`BMU_XLEN-1:0]         operand;
        logic [`BMU_TAG_W-1:0]        tag;
    } bmu_issued_t;

    typedef struct packed {
        logic [`BMU_XLEN-1:0]         value;
        logic [`BMU_TAG_W-1:0]        tag;
        logic                         illegal;
    } bmu_result_t;

endpackage

`default_nettype wire

// ==== source/bmu_op_pkg.sv ====
// op codes for clz, ctz and cpop only; code 3 is not an instruction and returns illegal.
`default_nettype none

package bmu_op_pkg;

    typedef enum logic [1:0] {
        OP_CLZ  = 2'd0,
        OP_CTZ  = 2'd1,
        OP_CPOP = 2'd2,
        OP_RSVD = 2'd3   // reserved, flagged illegal.
    } bmu_op_t;

    // one-hot style select, decoded once at issue.
    typedef struct packed {
        logic is_count;  // clz or ctz.
        logic is_pop;    // cpop.
        logic illegal;
    } bmu_sel_t;

endpackage

`default_nettype wire

// ==== source/bmu_defines.svh ====
// widths for the 32-bit count unit only; the 64-bit forms need BMU_XLEN 64 and BMU_CNT_W 6.
`ifndef BMU_DEFINES_SVH
`define BMU_DEFINES_SVH

// operand and result width.
`define BMU_XLEN 32

// width of an in-range count, log2 of BMU_XLEN.
`define BMU_CNT_W 5

// destination register tag, one of 32 registers.
`define BMU_TAG_W 5

`endif
